/* compile.f */
design/rx_pkg.sv
design/flow_lookup_table.sv
design/rx_state_table.sv
design/tx_req_builder.sv
design/rx_issue_ctrl.sv
design/rx_flow_top.sv
tests/tb_rx_flow.sv

/* run.sh */
#!/bin/sh
# Build the rx flow classifier testbench with Verilator and run it

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_rx_flow -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_rx_flow" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* tests/tb_rx_flow.sv */
`timescale 1ns/1ps

module tb_rx_flow;
    import rx_pkg::*;

    localparam int POOL_SIZE  = 12;
    localparam int WAIT_LIMIT = 50;

    logic                   clk;
    logic                   rst_n;
    logic                   hdr_val;
    rx_hdr_t                hdr;
    logic                   hdr_rdy;
    logic                   tx_req_val;
    tx_req_t                tx_req;
    logic                   tx_rdy;
    logic                   new_flow_val;
    new_flow_t              new_flow;
    logic                   drop_val;

    logic   [31:0]          rng_state;
    four_tuple_t            pool [POOL_SIZE];         // Peers that send headers
    four_tuple_t            flow_tuple [FLOW_CNT];
    logic   [SEQ_W-1:0]     flow_exp [FLOW_CNT];      // Model's expected receive seq
    int                     next_id;
    int                     errors;
    int                     errors_at_start;
    int                     tests_run;
    int                     tests_failed;
    string                  test_name;
    logic                   aborted;

    rx_flow_top i_dut (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.hdr_val       (hdr_val        )
        ,.hdr           (hdr            )
        ,.hdr_rdy       (hdr_rdy        )
        ,.tx_req_val    (tx_req_val     )
        ,.tx_req        (tx_req         )
        ,.tx_rdy        (tx_rdy         )
        ,.new_flow_val  (new_flow_val   )
        ,.new_flow      (new_flow       )
        ,.drop_val      (drop_val       )
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------
    // Random numbers and header building
    // ------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[16];
    endfunction

    function automatic rx_hdr_t make_hdr(int idx, logic syn, logic [SEQ_W-1:0] seq,
                                         logic [LEN_W-1:0] len);
        rx_hdr_t h;
        h.tuple       = pool[idx];
        h.seq_num     = seq;
        h.ack_num     = next_rand();
        h.flags       = '0;
        h.flags[syn ? TCP_FLAG_SYN : TCP_FLAG_ACK] = 1'b1;
        h.payload_len = len;
        return h;
    endfunction

    function automatic int flow_of(four_tuple_t t);
        int id;
        id = -1;
        for (int i = 0; i < next_id; i++) begin
            if (flow_tuple[i] == t) id = i;
        end
        return id;
    endfunction

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    task automatic model_hdr(input rx_hdr_t h, output logic drop, output logic is_new,
                             output tx_req_t tx, output new_flow_t nf);
        int   id;
        logic syn;
        id     = flow_of(h.tuple);
        syn    = h.flags[TCP_FLAG_SYN];
        drop   = 1'b1;
        is_new = 1'b0;
        tx     = '0;
        nf     = '0;
        tx.tuple.src_ip   = h.tuple.dst_ip;                 // Reply heads back to the peer
        tx.tuple.dst_ip   = h.tuple.src_ip;
        tx.tuple.src_port = h.tuple.dst_port;
        tx.tuple.dst_port = h.tuple.src_port;
        if (id < 0 && syn && next_id < FLOW_CNT) begin
            drop       = 1'b0;
            is_new     = 1'b1;
            tx.kind    = TX_SYN_ACK;
            tx.flowid  = FLOWID_W'(next_id);
            tx.seq_num = SERVER_ISN;
            tx.ack_num = h.seq_num + 32'd1;
            nf.flowid  = FLOWID_W'(next_id);
            nf.tuple   = h.tuple;
            flow_tuple[next_id] = h.tuple;
            flow_exp[next_id]   = tx.ack_num;
            next_id++;
        end else if (id >= 0 && !syn) begin
            drop       = 1'b0;
            tx.kind    = TX_ACK;
            tx.flowid  = FLOWID_W'(id);
            tx.seq_num = SERVER_ISN + 32'd1;
            if (h.seq_num == flow_exp[id]) tx.ack_num = h.seq_num + 32'(h.payload_len);
            else tx.ack_num = flow_exp[id];                 // Duplicate ACK
            flow_exp[id] = tx.ack_num;
        end
    endtask

    // ------------------------------------------------------------
    // Checks and reporting
    // ------------------------------------------------------------
    task automatic check_tx(input tx_req_t exp, input tx_req_t act);
        if (act !== exp) begin
            $display("** Error %s: expected tx_req %h, actual %h", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_new_flow(input new_flow_t exp, input new_flow_t act);
        if (act !== exp) begin
            $display("** Error %s: expected new_flow %h, actual %h", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_drop(input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected drop %b, actual %b", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    task automatic abort_run(input string what);
        report_failure({"timed out waiting for ", what});
        aborted = 1'b1;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s", test_name);
        end
    endtask

    // Hold < 0 gives random tx_rdy, otherwise tx_rdy stays low for hold cycles
    task automatic run_hdr(input rx_hdr_t h, input int hold);
        logic       exp_drop;
        logic       exp_new;
        tx_req_t    exp_tx;
        new_flow_t  exp_nf;
        int         n;
        if (aborted) return;
        model_hdr(h, exp_drop, exp_new, exp_tx, exp_nf);
        @(posedge clk);
        hdr_val <= 1'b1;
        hdr     <= h;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!hdr_rdy && n < WAIT_LIMIT);
        if (!hdr_rdy) begin
            abort_run("hdr_rdy");
            return;
        end
        @(posedge clk);                                     // Accepting edge
        hdr_val <= 1'b0;
        tx_rdy  <= (hold < 0) ? rand_bit() : (hold == 0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (!(drop_val || tx_req_val || new_flow_val) && hdr_rdy) begin
                report_failure("hdr_rdy high while a header is being classified");
            end
        end while (!(drop_val || tx_req_val || new_flow_val) && n < WAIT_LIMIT);
        if (!(drop_val || tx_req_val || new_flow_val)) begin
            abort_run("an outcome");
            return;
        end
        if (n != 3) begin
            report_failure($sformatf("outcome came %0d cycles after acceptance, not 3", n));
        end
        check_drop(exp_drop, drop_val);
        if (tx_req_val !== !exp_drop) report_failure("send request present when not expected");
        if (new_flow_val !== exp_new) report_failure("new-flow pulse present when not expected");
        if (exp_new && new_flow_val) check_new_flow(exp_nf, new_flow);
        if (!tx_req_val) return;
        n = 0;
        while (tx_req_val && n < WAIT_LIMIT) begin
            check_tx(exp_tx, tx_req);
            if (hdr_rdy) report_failure("hdr_rdy high while a send request is pending");
            @(posedge clk);
            n++;
            tx_rdy <= (hold < 0) ? rand_bit() : (n >= hold);
            @(negedge clk);
        end
        if (tx_req_val) begin
            abort_run("the send request to be consumed");
            return;
        end
        if (!hdr_rdy) report_failure("hdr_rdy did not return after the send was consumed");
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int                 idx;
        int                 id;
        logic               syn;
        logic [SEQ_W-1:0]   seq;
        clk          = 1'b0;
        rst_n       <= 1'b0;
        hdr_val     <= 1'b0;
        hdr         <= '0;
        tx_rdy      <= 1'b0;
        rng_state    = 32'he01e;
        next_id      = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i].src_ip   = next_rand();
            pool[i].dst_ip   = next_rand();
            pool[i].src_port = next_rand() >> 16;
            pool[i].dst_port = next_rand() >> 16;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset");
        @(negedge clk);
        if ({hdr_rdy, tx_req_val, new_flow_val, drop_val} !== 4'b1000) begin
            $display("** Error %s: expected rdy/tx/new/drop %b, actual %b", test_name,
                     4'b1000, {hdr_rdy, tx_req_val, new_flow_val, drop_val});
            errors++;
        end
        end_test();

        start_test("new_flow");
        run_hdr(make_hdr(0, 1'b1, next_rand(), 16'd0), 0);
        end_test();

        start_test("est_in_order");
        run_hdr(make_hdr(0, 1'b0, flow_exp[0], 16'd512), 0);
        end_test();

        start_test("est_out_of_order");
        run_hdr(make_hdr(0, 1'b0, flow_exp[0] + 32'd1000, 16'd100), 0);
        end_test();

        start_test("drop_unknown");
        run_hdr(make_hdr(1, 1'b0, next_rand(), 16'd64), 0);
        end_test();

        start_test("drop_repeat_syn");
        run_hdr(make_hdr(0, 1'b1, next_rand(), 16'd0), 0);
        end_test();

        start_test("drop_table_full");
        for (int i = 1; i < FLOW_CNT; i++) begin
            run_hdr(make_hdr(i, 1'b1, next_rand(), 16'd0), 0);
        end
        run_hdr(make_hdr(FLOW_CNT, 1'b1, next_rand(), 16'd0), 0);   // Ninth flow
        end_test();

        start_test("back_pressure");
        run_hdr(make_hdr(2, 1'b0, flow_exp[2], 16'd300), 6);
        run_hdr(make_hdr(3, 1'b0, flow_exp[3], 16'd40), 0);
        end_test();

        start_test("random");
        for (int k = 0; k < 400; k++) begin
            idx = (next_rand() >> 8) % POOL_SIZE;
            syn = ((next_rand() >> 4) % 3) == 0;
            id  = flow_of(pool[idx]);
            if (id >= 0 && rand_bit()) seq = flow_exp[id];
            else seq = next_rand();
            run_hdr(make_hdr(idx, syn, seq, 16'(next_rand() % 1461)), -1);
        end
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* design/rx_flow_top.sv */
`timescale 1ns/1ps

module rx_flow_top (
     input  logic                       clk
    ,input  logic                       rst_n

    ,input  logic                       hdr_val
    ,input  rx_pkg::rx_hdr_t            hdr
    ,output logic                       hdr_rdy

    ,output logic                       tx_req_val
    ,output rx_pkg::tx_req_t            tx_req
    ,input  logic                       tx_rdy

    ,output logic                       new_flow_val
    ,output rx_pkg::new_flow_t          new_flow
    ,output logic                       drop_val
);
    import rx_pkg::*;

    rx_hdr_t                hdr_q;

    logic                   hit;
    logic   [FLOWID_W-1:0]  hit_flowid;
    logic                   full;
    logic   [FLOWID_W-1:0]  free_flowid;
    logic                   insert;
    logic   [FLOWID_W-1:0]  insert_flowid;

    logic                   state_wr;
    logic                   state_init;
    logic   [FLOWID_W-1:0]  state_flowid;
    logic   [SEQ_W-1:0]     reply_ack;

    logic                   load;
    tx_kind_e               kind;
    logic   [FLOWID_W-1:0]  flowid;
    logic                   busy;

    rx_issue_ctrl issue_ctrl (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.hdr_val       (hdr_val        )
        ,.hdr           (hdr            )
        ,.hdr_rdy       (hdr_rdy        )
        ,.hdr_q         (hdr_q          )
        ,.hit           (hit            )
        ,.hit_flowid    (hit_flowid     )
        ,.full          (full           )
        ,.free_flowid   (free_flowid    )
        ,.insert        (insert         )
        ,.insert_flowid (insert_flowid  )
        ,.state_wr      (state_wr       )
        ,.state_init    (state_init     )
        ,.state_flowid  (state_flowid   )
        ,.load          (load           )
        ,.kind          (kind           )
        ,.flowid        (flowid         )
        ,.busy          (busy           )
        ,.new_flow_val  (new_flow_val   )
        ,.new_flow      (new_flow       )
        ,.drop_val      (drop_val       )
    );

    flow_lookup_table lookup_table (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.tuple         (hdr_q.tuple    )
        ,.hit           (hit            )
        ,.hit_flowid    (hit_flowid     )
        ,.full          (full           )
        ,.free_flowid   (free_flowid    )
        ,.insert        (insert         )
        ,.insert_flowid (insert_flowid  )
    );

    rx_state_table state_table (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.hdr_q         (hdr_q          )
        ,.state_flowid  (state_flowid   )
        ,.state_init    (state_init     )
        ,.state_wr      (state_wr       )
        ,.reply_ack     (reply_ack      )
    );

    tx_req_builder req_builder (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.load          (load           )
        ,.kind          (kind           )
        ,.flowid        (flowid         )
        ,.hdr_q         (hdr_q          )
        ,.reply_ack     (reply_ack      )
        ,.tx_req_val    (tx_req_val     )
        ,.tx_req        (tx_req         )
        ,.tx_rdy        (tx_rdy         )
        ,.busy          (busy           )
    );

endmodule

/* design/rx_issue_ctrl.sv */
`timescale 1ns/1ps

module rx_issue_ctrl (
     input  logic                           clk
    ,input  logic                           rst_n

    ,input  logic                           hdr_val
    ,input  rx_pkg::rx_hdr_t                hdr
    ,output logic                           hdr_rdy
    ,output rx_pkg::rx_hdr_t                hdr_q

    ,input  logic                           hit
    ,input  logic   [rx_pkg::FLOWID_W-1:0]  hit_flowid
    ,input  logic                           full
    ,input  logic   [rx_pkg::FLOWID_W-1:0]  free_flowid
    ,output logic                           insert
    ,output logic   [rx_pkg::FLOWID_W-1:0]  insert_flowid

    ,output logic                           state_wr
    ,output logic                           state_init
    ,output logic   [rx_pkg::FLOWID_W-1:0]  state_flowid

    ,output logic                           load
    ,output rx_pkg::tx_kind_e               kind
    ,output logic   [rx_pkg::FLOWID_W-1:0]  flowid
    ,input  logic                           busy

    ,output logic                           new_flow_val
    ,output rx_pkg::new_flow_t              new_flow
    ,output logic                           drop_val
);
    import rx_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DECIDE,
        ISSUE,
        WAIT_TX
    } state_e;

    typedef enum logic [1:0] {
        PATH_DROP,
        PATH_NEW,
        PATH_EST
    } path_e;

    state_e                 state;
    path_e                  path_q;
    logic   [FLOWID_W-1:0]  flowid_q;
    logic                   syn;

    assign hdr_rdy = (state == IDLE);
    assign syn     = hdr_q.flags[TCP_FLAG_SYN];

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (hdr_val) state <= DECIDE;
                DECIDE:  state <= ISSUE;
                ISSUE:   state <= (path_q == PATH_DROP) ? IDLE : WAIT_TX;
                WAIT_TX: if (!busy) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_val && hdr_rdy) begin
            hdr_q <= hdr;
        end
    end

    // Path choice, the only place SYN is looked at
    always_ff @(posedge clk) begin
        if (state == DECIDE) begin
            if (!hit && syn && !full) begin
                path_q   <= PATH_NEW;
                flowid_q <= free_flowid;
            end else if (hit && !syn) begin
                path_q   <= PATH_EST;
                flowid_q <= hit_flowid;
            end else begin
                path_q   <= PATH_DROP;
                flowid_q <= hit_flowid;
            end
        end
    end

    // ------------------------------------------------------------
    // Datapath strobes
    // ------------------------------------------------------------
    assign insert        = (state == ISSUE) && (path_q == PATH_NEW);
    assign insert_flowid = flowid_q;
    assign state_wr      = (state == ISSUE) && (path_q != PATH_DROP);
    assign state_init    = (path_q == PATH_NEW);
    assign state_flowid  = flowid_q;
    assign load          = (state == ISSUE) && (path_q != PATH_DROP);
    assign kind          = (path_q == PATH_NEW) ? TX_SYN_ACK : TX_ACK;
    assign flowid        = flowid_q;

    // Pulses line up with tx_req_val rising
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            new_flow_val <= 1'b0;
            drop_val     <= 1'b0;
        end else begin
            new_flow_val <= (state == ISSUE) && (path_q == PATH_NEW);
            drop_val     <= (state == ISSUE) && (path_q == PATH_DROP);
        end
    end

    always_ff @(posedge clk) begin
        if (state == ISSUE) begin
            new_flow.flowid <= flowid_q;
            new_flow.tuple  <= hdr_q.tuple;
        end
    end

    a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({load, drop_val}));

endmodule

/* design/tx_req_builder.sv */
`timescale 1ns/1ps

module tx_req_builder (
     input  logic                           clk
    ,input  logic                           rst_n

    ,input  logic                           load
    ,input  rx_pkg::tx_kind_e               kind
    ,input  logic   [rx_pkg::FLOWID_W-1:0]  flowid
    ,input  rx_pkg::rx_hdr_t                hdr_q
    ,input  logic   [rx_pkg::SEQ_W-1:0]     reply_ack

    ,output logic                           tx_req_val
    ,output rx_pkg::tx_req_t                tx_req
    ,input  logic                           tx_rdy
    ,output logic                           busy
);
    import rx_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_req_val <= 1'b0;
        end else if (load) begin
            tx_req_val <= 1'b1;
        end else if (tx_rdy) begin
            tx_req_val <= 1'b0;
        end
    end

    // Reply goes back to the peer, so swap the endpoints
    always_ff @(posedge clk) begin
        if (load) begin
            tx_req.kind           <= kind;
            tx_req.flowid         <= flowid;
            tx_req.tuple.src_ip   <= hdr_q.tuple.dst_ip;
            tx_req.tuple.dst_ip   <= hdr_q.tuple.src_ip;
            tx_req.tuple.src_port <= hdr_q.tuple.dst_port;
            tx_req.tuple.dst_port <= hdr_q.tuple.src_port;
            tx_req.seq_num        <= (kind == TX_SYN_ACK) ? SERVER_ISN : SERVER_ISN + 1'b1;
            tx_req.ack_num        <= reply_ack;
        end
    end

    assign busy = tx_req_val && !tx_rdy;    // Still held after this edge

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req_val && !tx_rdy |=> tx_req_val && $stable(tx_req));

endmodule

/* design/rx_state_table.sv */
`timescale 1ns/1ps

module rx_state_table (
     input  logic                           clk
    ,input  logic                           rst_n

    ,input  rx_pkg::rx_hdr_t                hdr_q
    ,input  logic   [rx_pkg::FLOWID_W-1:0]  state_flowid
    ,input  logic                           state_init
    ,input  logic                           state_wr
    ,output logic   [rx_pkg::SEQ_W-1:0]     reply_ack
);
    import rx_pkg::*;

    logic   [SEQ_W-1:0]     exp_seq [FLOW_CNT];   // Next expected receive seq
    logic   [FLOW_CNT-1:0]  flow_live;
    logic   [SEQ_W-1:0]     exp_cur;

    assign exp_cur = exp_seq[state_flowid];

    // ------------------------------------------------------------
    // Acknowledgement number for the reply
    // ------------------------------------------------------------
    always_comb begin
        if (state_init) begin
            reply_ack = hdr_q.seq_num + 1'b1;                  // SYN takes one seq
        end else if (hdr_q.seq_num == exp_cur) begin
            reply_ack = hdr_q.seq_num + SEQ_W'(hdr_q.payload_len);
        end else begin
            reply_ack = exp_cur;                                // Duplicate ACK
        end
    end

    always_ff @(posedge clk) begin
        if (state_wr) begin
            exp_seq[state_flowid] <= reply_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flow_live <= '0;
        end else if (state_wr && state_init) begin
            flow_live[state_flowid] <= 1'b1;
        end
    end

    // A lookup hit must point at an entry that was set up by a SYN
    a_est_after_init: assert property (@(posedge clk) disable iff (!rst_n)
        state_wr && !state_init |-> flow_live[state_flowid]);

endmodule

/* design/flow_lookup_table.sv */
`timescale 1ns/1ps

module flow_lookup_table (
     input  logic                           clk
    ,input  logic                           rst_n

    ,input  rx_pkg::four_tuple_t            tuple
    ,output logic                           hit
    ,output logic   [rx_pkg::FLOWID_W-1:0]  hit_flowid
    ,output logic                           full
    ,output logic   [rx_pkg::FLOWID_W-1:0]  free_flowid

    ,input  logic                           insert
    ,input  logic   [rx_pkg::FLOWID_W-1:0]  insert_flowid
);
    import rx_pkg::*;

    logic           [FLOW_CNT-1:0]  valid;
    four_tuple_t                    tuple_mem [FLOW_CNT];
    logic           [FLOW_CNT-1:0]  match;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (insert) begin
            valid[insert_flowid] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (insert) begin
            tuple_mem[insert_flowid] <= tuple;
        end
    end

    // ------------------------------------------------------------
    // Parallel compare and slot search
    // ------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < FLOW_CNT; i++) begin
            match[i] = valid[i] && (tuple_mem[i] == tuple);
        end
    end

    always_comb begin
        hit        = 1'b0;
        hit_flowid = '0;
        for (int i = 0; i < FLOW_CNT; i++) begin
            if (match[i]) begin
                hit        = 1'b1;
                hit_flowid = FLOWID_W'(i);
            end
        end
    end

    // Ids are never freed, so this walks 0, 1, 2 ...
    always_comb begin
        free_flowid = '0;
        for (int i = FLOW_CNT - 1; i >= 0; i--) begin
            if (!valid[i]) free_flowid = FLOWID_W'(i);
        end
    end

    assign full = &valid;

    a_no_insert_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        insert |-> !full);

endmodule

/* design/rx_pkg.sv */
package rx_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int FLOW_CNT  = 8;
    localparam int FLOWID_W  = 3;
    localparam int IP_ADDR_W = 32;
    localparam int PORT_W    = 16;
    localparam int SEQ_W     = 32;
    localparam int LEN_W     = 16;

    localparam logic [SEQ_W-1:0] SERVER_ISN = 32'h6a3c_0000; // Our ISN for every connection

    // Bit positions in the TCP flags byte
    localparam int TCP_FLAG_SYN = 1;
    localparam int TCP_FLAG_ACK = 4;

    // ------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------
    typedef struct packed {
        logic [IP_ADDR_W-1:0] src_ip;
        logic [IP_ADDR_W-1:0] dst_ip;
        logic [PORT_W-1:0]    src_port;
        logic [PORT_W-1:0]    dst_port;
    } four_tuple_t;

    typedef struct packed {
        four_tuple_t          tuple;
        logic [SEQ_W-1:0]     seq_num;
        logic [SEQ_W-1:0]     ack_num;
        logic [7:0]           flags;
        logic [LEN_W-1:0]     payload_len;
    } rx_hdr_t;

    typedef enum logic {
        TX_SYN_ACK = 1'b0,
        TX_ACK     = 1'b1
    } tx_kind_e;

    typedef struct packed {
        tx_kind_e             kind;
        logic [FLOWID_W-1:0]  flowid;
        four_tuple_t          tuple;    // Already addressed to the peer
        logic [SEQ_W-1:0]     seq_num;
        logic [SEQ_W-1:0]     ack_num;
    } tx_req_t;

    typedef struct packed {
        logic [FLOWID_W-1:0]  flowid;
        four_tuple_t          tuple;
    } new_flow_t;

endpackage
